/* board_pkg.sv */
package board_pkg;

    // ----------------------------------------
    // Seven-segment display

    typedef logic [7:0] seg_t;                 // abcdefgh, a in MSB, h is the dp
    typedef logic [6:0] hex_t;                 // Board digit, active low, a in bit 0

    localparam int n_digits = 6;

    typedef logic [n_digits - 1:0] digit_sel_t;  // One-hot scan select

    // Hex glyphs in abcdefgh order, dp clear
    localparam seg_t font [16] = '{
        8'hFC, 8'h60, 8'hDA, 8'hF2,            // 0 1 2 3
        8'h66, 8'hB6, 8'hBE, 8'hE0,            // 4 5 6 7
        8'hFE, 8'hF6, 8'hEE, 8'h3E,            // 8 9 A b
        8'h9C, 8'h7A, 8'h9E, 8'h8E             // C d E F
    };

    // ----------------------------------------
    // Switches and LEDs

    typedef logic [9:0] led_t;                 // Top six are the dp lamps
    typedef logic [9:0] sw_t;

    localparam int n_sw_leds = $bits(led_t) - n_digits;  // Low LEDs that mirror switches

endpackage

/* audio_pkg.sv */
package audio_pkg;

    // ----------------------------------------
    // Sample words

    typedef logic [23:0] mic_sample_t;         // Microphone word
    typedef logic [15:0] sound_t;              // DAC word

    // ----------------------------------------
    // I2S framing

    typedef logic [5:0] bit_idx_t;             // Position in a 64-bit frame

    localparam int slot_bits  = 32;            // Bits per channel slot
    localparam int frame_bits = 2 * slot_bits;

    typedef enum logic [1:0]
    {
        idle,
        skip,
        shift,
        done
    } i2s_state_t;

endpackage

/* bit_clock_timer.sv */
`timescale 1ns/1ps

module bit_clock_timer
#(
    parameter int bit_div  = 2,
    parameter int scan_div = 8
)
(
    input  logic                clk,
    input  logic                rst,
    output logic                sck,
    output logic                ws,
    output logic                sck_rise,
    output logic                sck_fall,
    output audio_pkg::bit_idx_t bit_idx,
    output logic                scan_tick
);

    import audio_pkg::*;

    localparam int half_w = $clog2(bit_div + 1);
    localparam int scan_w = $clog2(scan_div + 1);

    logic [half_w - 1:0] half_cnt;
    logic [scan_w - 1:0] scan_cnt;
    logic                half_end;

    // ----------------------------------------
    // Bit clock and frame position

    assign half_end = (half_cnt == half_w'(bit_div - 1));
    assign sck_rise = half_end & ~sck;           // sck goes high next edge
    assign sck_fall = half_end & sck;            // sck goes low next edge
    assign ws       = (bit_idx >= bit_idx_t'(slot_bits));  // Low in the left slot

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            half_cnt <= '0;
            sck      <= 1'b0;
            bit_idx  <= '0;
        end
        else if (half_end)
        begin
            half_cnt <= '0;
            sck      <= ~sck;
            if (sck)
                bit_idx <= bit_idx + 1'b1;       // Wraps at the frame end
        end
        else
            half_cnt <= half_cnt + 1'b1;
    end

    // ----------------------------------------
    // Display scan rate

    assign scan_tick = (scan_cnt == scan_w'(scan_div - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            scan_cnt <= '0;
        else if (scan_tick)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

endmodule

/* mic_i2s_receiver.sv */
`timescale 1ns/1ps

module mic_i2s_receiver
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sck_rise,
    input  logic                   ws,
    input  logic                   sd,
    output audio_pkg::mic_sample_t sample,
    output logic                   sample_done
);

    import audio_pkg::*;

    localparam int mic_bits = $bits(mic_sample_t);
    localparam int cnt_w    = $clog2(mic_bits);

    i2s_state_t            state;
    logic                  ws_q;
    logic                  ws_fall;
    logic [cnt_w - 1:0]    bit_cnt;
    logic [mic_bits - 2:0] shift_reg;            // All but the last bit of the word

    // With bit_div of 2 or more the edge is seen before the first sck rise
    assign ws_fall     = ws_q & ~ws;
    assign sample_done = (state == done);

    // ----------------------------------------
    // Frame state machine

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= idle;
            ws_q    <= 1'b0;
            bit_cnt <= '0;
            sample  <= '0;
        end
        else
        begin
            ws_q <= ws;
            case (state)
                idle:
                    if (ws_fall)
                        state <= skip;           // Left slot starts
                skip:
                    if (sck_rise)
                    begin
                        state   <= shift;        // One-bit I2S delay
                        bit_cnt <= '0;
                    end
                shift:
                    if (sck_rise)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == cnt_w'(mic_bits - 1))
                        begin
                            state  <= done;
                            sample <= {shift_reg, sd};   // LSB arrives here
                        end
                    end
                done:
                    state <= idle;
                default:
                    state <= idle;
            endcase
        end
    end

    // ----------------------------------------
    // Serial capture, MSB first

    always_ff @(posedge clk)
    begin
        if (state == shift && sck_rise)
            shift_reg <= {shift_reg[mic_bits - 3:0], sd};
    end

endmodule

/* audio_i2s_transmitter.sv */
`timescale 1ns/1ps

module audio_i2s_transmitter
(
    input  logic                clk,
    input  logic                rst,
    input  logic                sck_fall,
    input  audio_pkg::bit_idx_t bit_idx,
    input  audio_pkg::sound_t   sound,
    output logic                sdata
);

    import audio_pkg::*;

    localparam int sound_bits = $bits(sound_t);

    sound_t shift_reg;
    logic   frame_end;
    logic   active;

    assign frame_end = (bit_idx == bit_idx_t'(frame_bits - 1));

    // Data bits sit one position after the ws fall
    assign active = (bit_idx >= bit_idx_t'(1)) && (bit_idx <= bit_idx_t'(sound_bits));

    // ----------------------------------------
    // Load at the frame wrap, then shift out

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            shift_reg <= '0;                     // Silence in the first frame
        else if (sck_fall)
        begin
            if (frame_end)
                shift_reg <= sound;
            else if (active)
                shift_reg <= {shift_reg[sound_bits - 2:0], 1'b0};
        end
    end

    assign sdata = active ? shift_reg[sound_bits - 1] : 1'b0;  // Right slot stays zero

endmodule

/* hex_scan_display.sv */
`timescale 1ns/1ps

module hex_scan_display
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             scan_tick,
    input  audio_pkg::mic_sample_t           value,
    input  logic [board_pkg::n_digits - 1:0] dp_in,
    output board_pkg::seg_t                  abcdefgh,
    output board_pkg::digit_sel_t            digit
);

    import board_pkg::*;

    localparam int idx_w = $clog2(n_digits);

    logic [idx_w - 1:0] idx;
    logic [idx_w - 1:0] next_idx;
    logic [3:0]         nibble;
    seg_t               next_seg;

    // ----------------------------------------
    // Digit pointer and glyph lookup

    always_comb
    begin
        if (digit == '0 || idx == idx_w'(n_digits - 1))
            next_idx = '0;                       // First step or wrap
        else
            next_idx = idx + 1'b1;
    end

    assign nibble   = value[next_idx * 4 +: 4];
    assign next_seg = font[nibble] | seg_t'(dp_in[next_idx]);  // dp is the LSB

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            idx      <= '0;
            digit    <= '0;                      // Dark until the first tick
            abcdefgh <= '0;
        end
        else if (scan_tick)
        begin
            idx      <= next_idx;
            digit    <= digit_sel_t'(1) << next_idx;
            abcdefgh <= next_seg;
        end
    end

endmodule

/* static_seg_latch.sv */
`timescale 1ns/1ps

module static_seg_latch
(
    input  logic                             clk,
    input  logic                             rst,
    input  board_pkg::seg_t                  abcdefgh,
    input  board_pkg::digit_sel_t            digit,
    output board_pkg::hex_t                  hex0,
    output board_pkg::hex_t                  hex1,
    output board_pkg::hex_t                  hex2,
    output board_pkg::hex_t                  hex3,
    output board_pkg::hex_t                  hex4,
    output board_pkg::hex_t                  hex5,
    output logic [board_pkg::n_digits - 1:0] dp
);

    import board_pkg::*;

    localparam int seg_w = $bits(seg_t);
    localparam int hex_w = $bits(hex_t);

    seg_t hgfedcba;
    hex_t hex_q [n_digits];

    // ----------------------------------------
    // Segment order reversal, a ends up in bit 0

    for (genvar i = 0; i < seg_w; i++)
    begin : g_reverse
        assign hgfedcba[i] = abcdefgh[seg_w - 1 - i];
    end

    // ----------------------------------------
    // One sticky register per digit

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hex_q <= '{default: '1};             // All segments off
            dp    <= '0;
        end
        else
        begin
            for (int d = 0; d < n_digits; d++)
            begin
                if (digit[d])
                begin
                    hex_q[d] <= ~hgfedcba[hex_w - 1:0];  // Board digits are active low
                    dp[d]    <= hgfedcba[hex_w];
                end
            end
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];
    assign hex4 = hex_q[4];
    assign hex5 = hex_q[5];

endmodule

/* board_top.sv */
`timescale 1ns/1ps

module board_top
#(
    parameter int bit_div  = 2,
    parameter int scan_div = 8
)
(
    input  logic            clk,
    input  logic            rst,
    input  board_pkg::sw_t  sw,
    input  logic            mic_sd,
    output board_pkg::hex_t hex0,
    output board_pkg::hex_t hex1,
    output board_pkg::hex_t hex2,
    output board_pkg::hex_t hex3,
    output board_pkg::hex_t hex4,
    output board_pkg::hex_t hex5,
    output board_pkg::led_t led,
    output logic            i2s_sck,
    output logic            i2s_ws,
    output logic            dac_sdata
);

    import board_pkg::*;
    import audio_pkg::*;

    logic                  sck_rise;
    logic                  sck_fall;
    logic                  scan_tick;
    logic                  sample_done;
    bit_idx_t              bit_idx;
    mic_sample_t           mic_sample;
    sound_t                sound;
    seg_t                  abcdefgh;
    digit_sel_t            digit;
    logic [n_digits - 1:0] dp;

    // ----------------------------------------
    // Shared I2S timing, mic and DAC on one bit clock

    bit_clock_timer #(.bit_div(bit_div), .scan_div(scan_div)) i_timer
    (
        .clk       (clk),
        .rst       (rst),
        .sck       (i2s_sck),
        .ws        (i2s_ws),
        .sck_rise  (sck_rise),
        .sck_fall  (sck_fall),
        .bit_idx   (bit_idx),
        .scan_tick (scan_tick)
    );

    mic_i2s_receiver i_microphone
    (
        .clk         (clk),
        .rst         (rst),
        .sck_rise    (sck_rise),
        .ws          (i2s_ws),
        .sd          (mic_sd),
        .sample      (mic_sample),
        .sample_done (sample_done)
    );

    assign sound = mic_sample[$bits(mic_sample_t) - 1 -: $bits(sound_t)];  // Loopback

    audio_i2s_transmitter i_audio_out
    (
        .clk      (clk),
        .rst      (rst),
        .sck_fall (sck_fall),
        .bit_idx  (bit_idx),
        .sound    (sound),
        .sdata    (dac_sdata)
    );

    // ----------------------------------------
    // Lab display and static digit latch

    hex_scan_display i_lab_display
    (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .value     (mic_sample),
        .dp_in     (sw[n_digits - 1:0]),
        .abcdefgh  (abcdefgh),
        .digit     (digit)
    );

    static_seg_latch i_seg_latch
    (
        .clk      (clk),
        .rst      (rst),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .hex4     (hex4),
        .hex5     (hex5),
        .dp       (dp)
    );

    assign led = {dp, sw[n_sw_leds - 1:0]};     // Top LEDs stand in for the dp pins

endmodule

/* board_top_properties.sv */
`timescale 1ns/1ps

module board_top_properties
(
    input logic                  clk,
    input logic                  rst,
    input logic                  i2s_sck,
    input logic                  i2s_ws,
    input logic                  dac_sdata,
    input logic                  sample_done,
    input board_pkg::digit_sel_t digit
);

    // ----------------------------------------
    // I2S framing

    ws_on_sck_fall: assert property (@(posedge clk) disable iff (rst)
        $changed(i2s_ws) |-> $fell(i2s_sck))
        else $error("i2s_ws changed without a falling i2s_sck");

    right_slot_silent: assert property (@(posedge clk) disable iff (rst)
        i2s_ws |-> !dac_sdata)
        else $error("dac_sdata is high in the right slot");

    sample_done_pulse: assert property (@(posedge clk) disable iff (rst)
        sample_done |=> !sample_done)
        else $error("sample_done stayed high for more than one cycle");

    // ----------------------------------------
    // Display scan

    digit_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(digit))
        else $error("digit select has more than one bit set");

endmodule

bind board_top board_top_properties i_properties
(
    .clk         (clk),
    .rst         (rst),
    .i2s_sck     (i2s_sck),
    .i2s_ws      (i2s_ws),
    .dac_sdata   (dac_sdata),
    .sample_done (sample_done),
    .digit       (digit)
);

/* tb_board_top.sv */
`timescale 1ns/1ps

module tb_board_top;

    import board_pkg::*;
    import audio_pkg::*;

    localparam int bit_div      = 2;
    localparam int scan_div     = 8;
    localparam int n_frames     = 40;
    localparam int clk_period   = 10;
    localparam int frame_cycles = 2 * bit_div * frame_bits;   // 256 clk cycles
    localparam int timeout_ns   = 2 * n_frames * frame_cycles * clk_period;

    logic        clk;
    logic        rst;
    sw_t         sw;
    logic        mic_sd;
    hex_t        hex0;
    hex_t        hex1;
    hex_t        hex2;
    hex_t        hex3;
    hex_t        hex4;
    hex_t        hex5;
    led_t        led;
    logic        i2s_sck;
    logic        i2s_ws;
    logic        dac_sdata;

    hex_t        hex_out [n_digits];
    mic_sample_t sent [$];                     // One word per frame, in order
    mic_sample_t mic_word;
    sw_t         prev_sw;
    sound_t      dac_word;
    sound_t      expected_sound;
    logic [15:0] lfsr;
    logic        sck_prev;
    logic        ws_prev;
    logic        in_frame;
    logic        sw_check_due;
    int          pos;                          // sck falls since the ws fall
    int          audio_words;

    board_top #(.bit_div(bit_div), .scan_div(scan_div)) i_dut
    (
        .clk       (clk),
        .rst       (rst),
        .sw        (sw),
        .mic_sd    (mic_sd),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .hex4      (hex4),
        .hex5      (hex5),
        .led       (led),
        .i2s_sck   (i2s_sck),
        .i2s_ws    (i2s_ws),
        .dac_sdata (dac_sdata)
    );

    assign hex_out[0] = hex0;
    assign hex_out[1] = hex1;
    assign hex_out[2] = hex2;
    assign hex_out[3] = hex3;
    assign hex_out[4] = hex4;
    assign hex_out[5] = hex5;

    // ----------------------------------------
    // Random bits and reference rules

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0])
            next = next ^ 16'hB400;            // Galois taps 16 14 13 11
        return next;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    // Board digit is segments a..g reversed and inverted
    function automatic hex_t seg_to_hex(input seg_t seg);
        hex_t hex;
        for (int i = 0; i < $bits(hex_t); i++)
            hex[i] = ~seg[$bits(seg_t) - 1 - i];
        return hex;
    endfunction

    // ----------------------------------------
    // Failure reporting and compares

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_hex(input string name, input hex_t expected, input hex_t actual);
        if (actual !== expected)
            stop_with_failure($sformatf("error: %s expected %h got %h", name, expected, actual));
    endtask

    task automatic check_led(input string name, input led_t expected, input led_t actual);
        if (actual !== expected)
            stop_with_failure($sformatf("error: %s expected %h got %h", name, expected, actual));
    endtask

    task automatic check_sound(input string name, input sound_t expected, input sound_t actual);
        if (actual !== expected)
            stop_with_failure($sformatf("error: %s expected %h got %h", name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            stop_with_failure($sformatf("error: %s expected %h got %h", name, expected, actual));
    endtask

    task automatic check_reset_state();
        for (int d = 0; d < n_digits; d++)
            check_hex($sformatf("hex%0d", d), '1, hex_out[d]);
        check_led("led", '0, led);             // Switches are zero here
        check_bit("i2s_sck", 1'b0, i2s_sck);
        check_bit("i2s_ws", 1'b0, i2s_ws);
        check_bit("dac_sdata", 1'b0, dac_sdata);
    endtask

    task automatic wait_sample_done();
        do
            @(negedge clk);
        while (i_dut.sample_done !== 1'b1);
    endtask

    // New mic word and switches at each left slot start
    task automatic start_frame();
        logic [31:0] bits;
        mic_sample_t prev_word;
        draw_bits($bits(mic_sample_t), bits);
        mic_word = bits[23:0];
        sent.push_back(mic_word);
        if (sent.size() == 1)
            expected_sound = '0;               // DAC sends silence in frame 0
        else
        begin
            prev_word      = sent[sent.size() - 2];
            expected_sound = prev_word[23:8];
        end
        draw_bits($bits(sw_t), bits);
        prev_sw      = sw;
        sw           = bits[9:0];
        sw_check_due = 1'b1;
        in_frame     = 1'b1;
        pos          = 0;
        dac_word     = '0;
    endtask

    // ----------------------------------------
    // Clock, watchdog, microphone and DAC side

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        #(timeout_ns);
        stop_with_failure("timeout: the frames did not complete in the expected time");
    end

    initial
    begin
        forever
        begin
            @(negedge clk);
            if (sw_check_due)
            begin
                check_led("led", {prev_sw[n_digits - 1:0], sw[n_sw_leds - 1:0]}, led);
                sw_check_due = 1'b0;
            end
            if (sck_prev && !i2s_sck)
            begin
                // ws is high for the second 32 bits of each 64-bit frame
                if (in_frame)
                    check_bit("i2s_ws", ((pos + 1) % frame_bits) >= slot_bits, i2s_ws);
                if (ws_prev && !i2s_ws)
                    start_frame();
                else
                    pos++;
                // Next bit goes out after each sck fall, MSB one bit after ws
                if (pos >= 1 && pos <= $bits(mic_sample_t))
                    mic_sd = mic_word[$bits(mic_sample_t) - pos];
                else
                    mic_sd = 1'b0;
            end
            if (!sck_prev && i2s_sck && in_frame && !i2s_ws && pos >= 1 &&
                pos <= $bits(sound_t))
            begin
                dac_word = {dac_word[$bits(sound_t) - 2:0], dac_sdata};
                if (pos == $bits(sound_t))
                begin
                    check_sound("dac_sdata", expected_sound, dac_word);
                    audio_words++;
                end
            end
            sck_prev = i2s_sck;
            ws_prev  = i2s_ws;
        end
    end

    // ----------------------------------------
    // Reset, then one display check per captured sample

    initial
    begin
        rst            = 1'b1;
        sw             = '0;
        mic_sd         = 1'b0;
        lfsr           = 16'd54;
        mic_word       = '0;
        prev_sw        = '0;
        dac_word       = '0;
        expected_sound = '0;
        sck_prev       = 1'b0;
        ws_prev        = 1'b0;
        in_frame       = 1'b0;
        sw_check_due   = 1'b0;
        pos            = 0;
        audio_words    = 0;
        repeat (3) @(negedge clk);
        check_reset_state();
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        for (int k = 0; k < n_frames; k++)
        begin
            wait_sample_done();
            repeat (6 * scan_div + 3) @(negedge clk);   // Every digit rescanned
            for (int d = 0; d < n_digits; d++)
                check_hex($sformatf("hex%0d", d), seg_to_hex(font[sent[k][4 * d +: 4]]),
                          hex_out[d]);
            check_led("led", {sw[n_digits - 1:0], sw[n_sw_leds - 1:0]}, led);
        end
        if (audio_words < n_frames)
            stop_with_failure("too few DAC words were received during the run");
        else
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

/* verilog.f */
board_pkg.sv
audio_pkg.sv
bit_clock_timer.sv
mic_i2s_receiver.sv
audio_i2s_transmitter.sv
hex_scan_display.sv
static_seg_latch.sv
board_top.sv
board_top_properties.sv
tb_board_top.sv

/* Makefile */
.PHONY: compile run clean

compile: obj_dir/Vtb_board_top

obj_dir/Vtb_board_top: verilog.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	    --top-module tb_board_top -o Vtb_board_top -f verilog.f

run: compile
	./obj_dir/Vtb_board_top

clean:
	rm -rf obj_dir
